//--- Makefile
# Verilator flow for the oled spi peripheral; run from the project root

VERILATOR ?= verilator
TOP       ?= oled_tb
FLIST     ?= flist.f
FLAGS     ?= --assert
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

# compile the testbench and design into a standalone model
build:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST)

# pass only when the model prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
rtl/oled_pkg.sv
rtl/oled_bus_decode.sv
rtl/oled_req_fifo.sv
rtl/oled_spi_serializer.sv
rtl/oled_top.sv
sim/oled_tb.sv

//--- rtl/oled_bus_decode.sv
// combinational write decode; offsets above 3 are dropped without a push or a flag
`timescale 1ns/1ps

module oled_bus_decode (
   input  logic                clk,
   input  logic                rst,
   input  logic                wstrb, // one cycle write pulse
   input  logic [3:0]          waddr, // word offset
   input  logic [31:0]         wdata,
   output logic                push,  // same cycle as wstrb
   output oled_pkg::oled_req_t req
);

   logic known; // offset maps to a request kind

   always_comb begin
      known    = 1'b1;
      req.kind = oled_pkg::KIND_CTRL;
      req.data = 16'h0000;
      case (waddr)
         oled_pkg::REG_CTRL: begin
            req.kind = oled_pkg::KIND_CTRL;
            req.data = {14'h0000, wdata[1:0]}; // res release, cs force
         end
         oled_pkg::REG_CMD: begin
            req.kind = oled_pkg::KIND_CMD;
            req.data = {8'h00, wdata[7:0]};
         end
         oled_pkg::REG_DAT8: begin
            req.kind = oled_pkg::KIND_DAT8;
            req.data = {8'h00, wdata[7:0]};
         end
         oled_pkg::REG_DAT16: begin
            req.kind = oled_pkg::KIND_DAT16;
            req.data = wdata[15:0]; // upper half-word ignored
         end
         default: known = 1'b0; // unmapped offset
      endcase
   end

   assign push = wstrb && known;

   // a queue entry must come from a bus write, never from decode alone
   a_push_needs_strobe: assert property (
      @(posedge clk) disable iff (rst) push |-> wstrb
   ) else $error("push without write strobe");

endmodule

//--- rtl/oled_pkg.sv
// shared types and register map for the oled spi peripheral; payload is at most 16 bits
package oled_pkg;

   // request kind carried through the queue
   typedef enum logic [1:0] {
      KIND_CTRL  = 2'd0, // cs force and panel reset levels
      KIND_CMD   = 2'd1, // 8-bit command, dc low
      KIND_DAT8  = 2'd2, // 8-bit data, dc high
      KIND_DAT16 = 2'd3  // 16-bit data, dc high
   } oled_kind_e;

   // one queued request, 18 bits
   // ctrl uses data[0] as cs force and data[1] as reset release
   // byte kinds keep the byte in data[7:0]
   typedef struct packed {
      oled_kind_e  kind;
      logic [15:0] data;
   } oled_req_t;

   // panel side pins, all registered in the serializer
   typedef struct packed {
      logic din;   // serial data, changes on falling sclk
      logic sclk;  // serial clock, free running
      logic cs_n;  // chip select, active low
      logic dc;    // data high, command low
      logic res_n; // panel reset, active low
   } oled_pins_t;

   // word offsets of the write port
   localparam logic [3:0] REG_CTRL  = 4'd0;
   localparam logic [3:0] REG_CMD   = 4'd1;
   localparam logic [3:0] REG_DAT8  = 4'd2;
   localparam logic [3:0] REG_DAT16 = 4'd3;

   // bit positions inside a ctrl payload
   localparam int CTRL_CS_FORCE = 0;
   localparam int CTRL_RES_REL  = 1;

   // frame lengths loaded into the bit counter
   localparam logic [4:0] LEN_BYTE = 5'd8;
   localparam logic [4:0] LEN_WORD = 5'd16;

endpackage

//--- rtl/oled_req_fifo.sv
// request queue of 2**FIFO_DEPTH_LOG2 entries; a push while full is lost and flagged until reset
`timescale 1ns/1ps

module oled_req_fifo #(
   parameter int FIFO_DEPTH_LOG2 = 2
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                push,
   input  oled_pkg::oled_req_t req,
   input  logic                pop,     // only when not empty
   output oled_pkg::oled_req_t head,    // oldest entry
   output logic                empty,
   output logic                full,
   output logic                overrun  // sticky
);

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

   oled_pkg::oled_req_t           mem [DEPTH]; // payload store, no reset
   logic [FIFO_DEPTH_LOG2:0]      wr_ptr;      // extra msb tells wrap
   logic [FIFO_DEPTH_LOG2:0]      rd_ptr;
   logic                          wr_en;

   // pointers equal -> empty, equal except msb -> full
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                  (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

   // a same-cycle pop frees the slot for a push into a full queue
   assign wr_en = push && (!full || pop);

   assign head = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= req;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         overrun <= 1'b0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         if (push && full && !pop) begin
            overrun <= 1'b1; // write dropped
         end
      end
   end

   // the serializer must never take a stale head
   a_no_pop_empty: assert property (
      @(posedge clk) disable iff (rst) pop |-> !empty
   ) else $error("pop while queue empty");

endmodule

//--- rtl/oled_spi_serializer.sv
// spi, msb first; sclk period 2**SCLK_DIV_LOG2 clocks (at least 2); start waits for divider
`timescale 1ns/1ps

module oled_spi_serializer #(
   parameter int SCLK_DIV_LOG2 = 2
) (
   input  logic                 clk,
   input  logic                 rst,
   input  oled_pkg::oled_req_t  head,   // valid while empty is low
   input  logic                 empty,
   output logic                 pop,    // taken with head in this cycle
   output logic                 active, // high from load to frame end
   output oled_pkg::oled_pins_t pins
);

   logic [SCLK_DIV_LOG2-1:0] div_cnt;  // free running divider
   logic                     tick;     // counter all ones, sclk about to fall
   logic                     shifting; // cs already low, bits on the wire
   logic [4:0]               bit_cnt;  // bits left, including the one on din
   logic [15:0]              shifter;  // msb drives din
   logic                     cs_force; // hold cs low between frames
   logic                     cs_n;
   logic                     dc;
   logic                     res_n;

   if (SCLK_DIV_LOG2 < 1) begin : g_div_check
      $error("SCLK_DIV_LOG2 must be at least 1");
   end

   assign tick = &div_cnt;
   assign pop  = !active && !empty; // idle and something queued

   always_ff @(posedge clk) begin
      if (rst) div_cnt <= '0;
      else     div_cnt <= div_cnt + 1'b1;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         active   <= 1'b0;
         shifting <= 1'b0;
         bit_cnt  <= 5'd0;
         shifter  <= 16'h0000; // din low out of reset
         cs_force <= 1'b0;
         cs_n     <= 1'b1;
         dc       <= 1'b0;
         res_n    <= 1'b0;     // panel held in reset
      end else if (pop) begin
         if (head.kind == oled_pkg::KIND_CTRL) begin
            // level change only, din and sclk untouched
            cs_force <= head.data[oled_pkg::CTRL_CS_FORCE];
            cs_n     <= !head.data[oled_pkg::CTRL_CS_FORCE];
            res_n    <= head.data[oled_pkg::CTRL_RES_REL];
         end else begin
            active   <= 1'b1;
            shifting <= 1'b0;
            cs_n     <= 1'b1;  // frame opens on the next tick
            res_n    <= 1'b1;  // any byte releases panel reset
            dc       <= (head.kind != oled_pkg::KIND_CMD);
            if (head.kind == oled_pkg::KIND_DAT16) begin
               shifter <= head.data;
               bit_cnt <= oled_pkg::LEN_WORD;
            end else begin
               shifter <= {head.data[7:0], 8'h00}; // byte left aligned
               bit_cnt <= oled_pkg::LEN_BYTE;
            end
         end
      end else if (active && tick) begin
         if (!shifting) begin
            cs_n     <= 1'b0;  // one tick ahead of the first bit
            shifting <= 1'b1;
         end else if (bit_cnt == 5'd1) begin
            // last bit was sampled on the rising edge just gone
            bit_cnt  <= 5'd0;
            shifter  <= {shifter[14:0], 1'b0}; // din back to zero
            shifting <= 1'b0;
            active   <= 1'b0;
            cs_n     <= !cs_force;
         end else begin
            bit_cnt <= bit_cnt - 5'd1;
            shifter <= {shifter[14:0], 1'b0};
         end
      end
   end

   // all pins come straight from registers
   assign pins.din   = shifter[15];
   assign pins.sclk  = div_cnt[SCLK_DIV_LOG2-1];
   assign pins.cs_n  = cs_n;
   assign pins.dc    = dc;
   assign pins.res_n = res_n;

   // the panel samples on rising sclk, so din and dc may only move
   // at a falling edge while it is selected
   a_stable_when_selected: assert property (
      @(posedge clk) disable iff (rst)
      (!cs_n && $past(!cs_n) && !$past(tick)) |-> ($stable(dc) && $stable(shifter[15]))
   ) else $error("din or dc moved off a tick while selected");

endmodule

//--- rtl/oled_top.sv
// oled spi peripheral top; write only, no readback, wbusy is simply queue full
`timescale 1ns/1ps

module oled_top #(
   parameter int FIFO_DEPTH_LOG2 = 2, // queue holds 2**n requests
   parameter int SCLK_DIV_LOG2   = 2  // sclk = clk / 2**n
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 wstrb,
   input  logic [3:0]           waddr,
   input  logic [31:0]          wdata,
   output logic                 wbusy,   // further writes would be lost
   output logic                 busy,    // queue or wire still working
   output logic                 overrun, // sticky lost-write flag
   output oled_pkg::oled_pins_t pins
);

   logic                push;
   oled_pkg::oled_req_t req;
   oled_pkg::oled_req_t head;
   logic                empty;
   logic                full;
   logic                pop;
   logic                active;

   oled_bus_decode decode_i (
      .clk   (clk),
      .rst   (rst),
      .wstrb (wstrb),
      .waddr (waddr),
      .wdata (wdata),
      .push  (push),
      .req   (req)
   );

   oled_req_fifo #(
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) fifo_i (
      .clk     (clk),
      .rst     (rst),
      .push    (push),
      .req     (req),
      .pop     (pop),
      .head    (head),
      .empty   (empty),
      .full    (full),
      .overrun (overrun)
   );

   oled_spi_serializer #(
      .SCLK_DIV_LOG2 (SCLK_DIV_LOG2)
   ) ser_i (
      .clk    (clk),
      .rst    (rst),
      .head   (head),
      .empty  (empty),
      .pop    (pop),
      .active (active),
      .pins   (pins)
   );

   assign wbusy = full;            // no delay
   assign busy  = !empty || active;

endmodule

//--- sim/oled_tb.sv
// run from the project root, reads sim/oled_trace.txt; frames are checked in order, not by cycle
`timescale 1ns/1ps

module oled_tb;

   localparam int          TIMEOUT_CYCLES = 2000;                 // per wait loop
   localparam string       TRACE_FILE     = "sim/oled_trace.txt";
   localparam logic [31:0] SEED           = 32'he287_2c5b;

   // one frame as seen on the wire
   typedef struct packed {
      logic        dc;
      logic [4:0]  len;   // bits captured
      logic [15:0] value; // msb first, right aligned
   } frame_t;

   logic                 clk;
   logic                 rst;
   logic                 wstrb;
   logic [3:0]           waddr;
   logic [31:0]          wdata;
   logic                 wbusy;
   logic                 busy;
   logic                 overrun;
   oled_pkg::oled_pins_t pins;

   frame_t      frames [$]; // closed frames, oldest first
   logic        mon_sclk;   // sclk at the previous falling clk
   logic        mon_cs_n;   // cs_n at the previous falling clk
   logic        mon_busy;   // busy at the previous falling clk
   logic        mon_dc;
   logic [4:0]  mon_len;
   logic [15:0] mon_value;
   logic        burst;      // post writes back to back

   oled_top dut_i (
      .clk     (clk),
      .rst     (rst),
      .wstrb   (wstrb),
      .waddr   (waddr),
      .wdata   (wdata),
      .wbusy   (wbusy),
      .busy    (busy),
      .overrun (overrun),
      .pins    (pins)
   );

   always #5 clk = ~clk; // 10 ns period

   // serial line monitor, pins are registered so the falling clk edge sees them settled
   always @(negedge clk) begin
      if (rst) begin
         mon_sclk  <= 1'b0;
         mon_cs_n  <= 1'b1;
         mon_busy  <= 1'b0;
         mon_dc    <= 1'b0;
         mon_len   <= 5'd0;
         mon_value <= 16'h0000;
      end else begin
         mon_sclk <= pins.sclk;
         mon_cs_n <= pins.cs_n;
         mon_busy <= busy;
         // idle clocks under a forced select carry no data
         // a ctrl entry keeps busy high for one sample only
         if (!pins.cs_n && busy && mon_busy && pins.sclk && !mon_sclk) begin
            mon_len   <= mon_len + 5'd1;
            mon_value <= {mon_value[14:0], pins.din}; // panel samples here
            mon_dc    <= pins.dc;
         end
         if (pins.cs_n && !mon_cs_n) begin // select released, frame done
            if (mon_len != 5'd0) frames.push_back(frame_t'{mon_dc, mon_len, mon_value});
            mon_len   <= 5'd0;
            mon_value <= 16'h0000;
         end
      end
   end

   task automatic abort(input string msg);
      $display("%0s (time %0t)", msg, $time);
      $display("Errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      if (actual !== expected) begin
         $display("[FAIL] %0t %0s: got %0h, expected %0h", $time, what, actual, expected);
         $display("Errors found");
         $fatal(1, "first mismatch");
      end
   endtask

   // one bus write; outside a burst it waits a random gap and for room in the queue
   task automatic post_write(input logic [3:0] off, input logic [31:0] data);
      int gap;
      int waited;
      if (!burst) begin
         gap = int'($urandom_range(3, 0));
         repeat (gap) @(negedge clk);
         waited = 0;
         while (wbusy) begin
            if (waited == TIMEOUT_CYCLES) abort("timed out waiting for wbusy to fall");
            waited = waited + 1;
            @(negedge clk);
         end
      end
      wstrb = 1'b1; // sampled on the next rising edge
      waddr = off;
      wdata = data;
      @(negedge clk);
      wstrb = 1'b0;
      waddr = 4'h0;
      wdata = 32'h0000_0000;
   endtask

   task automatic wait_idle();
      int waited;
      waited = 0;
      while (busy) begin
         if (waited == TIMEOUT_CYCLES) abort("timed out waiting for busy to fall");
         waited = waited + 1;
         @(negedge clk);
      end
   endtask

   task automatic check_frame(input int dc, input int len, input logic [31:0] value);
      frame_t got;
      int     waited;
      waited = 0;
      while (frames.size() == 0) begin
         if (waited == TIMEOUT_CYCLES) abort("timed out waiting for a serial frame");
         waited = waited + 1;
         @(negedge clk);
      end
      got = frames.pop_front();
      check(32'(got.dc), 32'(dc), "frame dc");
      check(32'(got.len), 32'(len), "frame length");
      check(32'(got.value), value, "frame value");
   endtask

   task automatic check_level(input logic [63:0] name, input int expected);
      logic [31:0] actual;
      actual = 32'h0;
      case (name)
         64'("cs_n"):    actual = 32'(pins.cs_n);
         64'("res_n"):   actual = 32'(pins.res_n);
         64'("dc"):      actual = 32'(pins.dc);
         64'("din"):     actual = 32'(pins.din);
         64'("wbusy"):   actual = 32'(wbusy);
         64'("busy"):    actual = 32'(busy);
         64'("overrun"): actual = 32'(overrun);
         64'("frames"):  actual = 32'(frames.size()); // frames not yet checked
         default:        abort("unknown signal name in a level record of the trace");
      endcase
      check(actual, 32'(expected), $sformatf("level of %0s", name));
   endtask

   initial begin
      logic [63:0]      op;
      logic [63:0]      name;
      logic [8*128-1:0] rest;
      logic [31:0]      off;
      logic [31:0]      data;
      int               fd;
      int               rc;
      int               n;
      int               len;
      clk    = 1'b0;
      rst    = 1'b1;
      wstrb  = 1'b0;
      waddr  = 4'h0;
      wdata  = 32'h0000_0000;
      burst  = 1'b0;
      void'($urandom(SEED)); // only seeding of the run
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0) abort("could not open the trace file");
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      rc = $fscanf(fd, "%s", op);
      while (rc == 1) begin
         if (op == 64'("#")) begin
            rc = $fgets(rest, fd); // comment, skip the line
         end else if (op == 64'("W")) begin
            rc = $fscanf(fd, "%h %h", off, data);
            if (rc != 2) abort("malformed write record in the trace");
            post_write(off[3:0], data);
         end else if (op == 64'("B")) begin
            rc = $fscanf(fd, "%d", n);
            if (rc != 1) abort("malformed burst record in the trace");
            burst = (n != 0);
         end else if (op == 64'("F")) begin
            rc = $fscanf(fd, "%d %d %h", n, len, data);
            if (rc != 3) abort("malformed frame record in the trace");
            check_frame(n, len, data);
         end else if (op == 64'("L")) begin
            rc = $fscanf(fd, "%s %d", name, n);
            if (rc != 2) abort("malformed level record in the trace");
            check_level(name, n);
         end else if (op == 64'("I")) begin
            wait_idle();
         end else begin
            abort("unknown record type in the trace");
         end
         rc = $fscanf(fd, "%s", op);
      end
      $fclose(fd);
      $display("No errors");
      $finish;
   end

endmodule

//--- sim/oled_trace.txt
# records: W off data (hex) | B on (dec) | F dc len (dec) value (hex) | L name level (dec) | I
# I waits for busy low; F takes the oldest captured frame; L frames counts unchecked frames
# reset state before any write
L cs_n 1
L res_n 0
L dc 0
L wbusy 0
L busy 0
L overrun 0
# command byte with dc low, then data byte with dc high
W 1 000000A5
F 0 8 A5
W 2 1234563C
F 1 8 3C
I
L res_n 1
# half-word, upper wdata ignored
W 3 DEADBEEF
F 1 16 BEEF
I
# mixed sequence, reset pulled low behind the queued bytes
W 1 00000081
W 2 0000007F
W 3 0000A55A
W 0 00000000
I
F 0 8 81
F 1 8 7F
F 1 16 A55A
L res_n 0
L cs_n 1
W 0 00000002
W 1 000000AF
I
F 0 8 AF
L res_n 1
# burst: one frame on the wire plus four queued, the sixth write is lost
B 1
W 1 00000001
W 2 00000002
W 2 00000003
W 3 00000404
W 1 00000005
W 2 00000006
B 0
L wbusy 1
L overrun 1
I
F 0 8 01
F 1 8 02
F 1 8 03
F 1 16 0404
F 0 8 05
L frames 0
L wbusy 0
L overrun 1
# unknown offset gives nothing
W 7 000000FF
L busy 0
I
L frames 0
# force select low while idle, then release it
W 0 00000003
I
L cs_n 0
L res_n 1
W 0 00000002
I
L cs_n 1
L frames 0
